/* project.f */
+incdir+include
src/isa_pkg.sv
src/sched_pkg.sv
src/latency_pipe.sv
src/issue_unit.sv
src/fu_bank.sv
src/cdb_driver.sv
src/exec_core.sv
bench/exec_core_assert.sv
bench/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exec_core_tb -f project.f -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_core +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* bench/exec_core_tb.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module exec_core_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 2000;
    localparam int LAT_LS_MULT  = (`EXEC_LS_LAT > `EXEC_MULT_LAT) ? `EXEC_LS_LAT : `EXEC_MULT_LAT;
    localparam int LAT_BR_ALU   = (`EXEC_BR_LAT > `EXEC_ALU_LAT) ? `EXEC_BR_LAT : `EXEC_ALU_LAT;
    localparam int MAX_LAT      = (LAT_LS_MULT > LAT_BR_ALU) ? LAT_LS_MULT : LAT_BR_ALU;
    localparam int WATCHDOG     = RESET_CYCLES + 1 + NUM_CYCLES + MAX_LAT + 20;

    logic                      clk = 1'b0;
    logic                      reset;
    logic [3:0]                req;
    sched_pkg::rob_tag_t [3:0] req_tag;
    isa_pkg::op_e [3:0]        req_op;
    isa_pkg::data_t [3:0]      req_a;
    isa_pkg::data_t [3:0]      req_b;
    logic [3:0]                grant;
    logic                      cdb_valid;
    isa_pkg::fu_class_e        cdb_class;
    sched_pkg::rob_tag_t       cdb_tag;
    isa_pkg::data_t            cdb_data;
    logic                      cdb_is_store;

    // lanes still waiting for their grant
    logic [3:0] held;
    int         errors;
    int         cycle;

    // expected broadcasts, indexed by cycle mod 16
    logic                exp_valid [16];
    isa_pkg::fu_class_e  exp_class [16];
    sched_pkg::rob_tag_t exp_tag [16];
    isa_pkg::data_t      exp_data [16];
    logic                exp_store [16];

    // first cycle a unit can take a new grant
    int free_at [4][`EXEC_NUM_MULT];

    exec_core u_exec_core (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic int class_latency(input int c);
        case (c)
            0: return `EXEC_LS_LAT;
            1: return `EXEC_MULT_LAT;
            2: return `EXEC_BR_LAT;
            default: return `EXEC_ALU_LAT;
        endcase
    endfunction

    function automatic isa_pkg::data_t expected_result(input int c, input isa_pkg::op_e op,
            input isa_pkg::data_t a, input isa_pkg::data_t b);
        if (c == 0) return a + b;
        if (c == 1) return a * b;
        if (c == 2) begin
            case (op)
                isa_pkg::BR_EQ:  return isa_pkg::data_t'(a == b);
                isa_pkg::BR_LTU: return isa_pkg::data_t'(a < b);
                isa_pkg::BR_NE:  return isa_pkg::data_t'(a != b);
                default:         return isa_pkg::data_t'(1);
            endcase
        end
        case (op)
            isa_pkg::OP_ADD: return a + b;
            isa_pkg::OP_SUB: return a - b;
            isa_pkg::OP_AND: return a & b;
            default:         return a ^ b;
        endcase
    endfunction

    // cdb outputs here come from the last rising edge
    task automatic check_broadcast(input int j);
        int s;
        s = j % 16;
        assert (cdb_valid == exp_valid[s]) else begin
            errors++;
            $display("ERROR %0t: cdb_valid is %0b, expected %0b", $time, cdb_valid, exp_valid[s]);
        end
        if (cdb_valid && exp_valid[s]) begin
            assert (cdb_class == exp_class[s] && cdb_tag == exp_tag[s]
                    && cdb_data == exp_data[s]) else begin
                errors++;
                $display("ERROR %0t: cdb class %0d tag %0d data %h, expected %0d %0d %h", $time,
                         cdb_class, cdb_tag, cdb_data, exp_class[s], exp_tag[s], exp_data[s]);
            end
            if (exp_class[s] == isa_pkg::FU_LS) begin
                assert (cdb_is_store == exp_store[s]) else begin
                    errors++;
                    $display("ERROR %0t: cdb_is_store is %0b, expected %0b", $time,
                             cdb_is_store, exp_store[s]);
                end
            end
        end
        exp_valid[s] = 1'b0;
    endtask

    task automatic drive_lanes(input logic active);
        int chance;
        for (int c = 0; c < 4; c++) begin
            // multiply lane asks more often to fill both multipliers
            chance = (c == 1) ? 3 : 2;
            if (!held[c]) begin
                if (active && ($urandom % 4) < chance) begin
                    req[c]     = 1'b1;
                    req_tag[c] = sched_pkg::rob_tag_t'($urandom);
                    req_op[c]  = isa_pkg::op_e'(2'($urandom));
                    req_a[c]   = $urandom;
                    req_b[c]   = (($urandom % 4) == 0) ? req_a[c] : $urandom;
                end else begin
                    req[c] = 1'b0;
                end
            end
        end
    endtask

    // classes in priority order, a grant needs a free unit and a free landing slot
    task automatic model_grants(input int j);
        int   lat;
        int   slot;
        int   unit;
        int   n;
        logic exp_grant;
        for (int c = 0; c < 4; c++) begin
            lat  = class_latency(c);
            slot = (j + lat + 1) % 16;
            n    = (c == 1) ? `EXEC_NUM_MULT : 1;
            unit = -1;
            for (int u = n - 1; u >= 0; u--) begin
                if (free_at[c][u] <= j) begin
                    unit = u;
                end
            end
            exp_grant = req[c] && unit >= 0 && !exp_valid[slot];
            assert (grant[c] == exp_grant) else begin
                errors++;
                $display("ERROR %0t: grant on lane %0d is %0b, expected %0b", $time, c,
                         grant[c], exp_grant);
            end
            if (exp_grant) begin
                exp_valid[slot]  = 1'b1;
                exp_class[slot]  = isa_pkg::fu_class_e'(2'(c));
                exp_tag[slot]    = req_tag[c];
                exp_data[slot]   = expected_result(c, req_op[c], req_a[c], req_b[c]);
                exp_store[slot]  = req_op[c][0];
                free_at[c][unit] = j + lat;
            end
            held[c] = req[c] && !grant[c];
        end
    endtask

    task automatic run_cycle(input int j, input logic active);
        @(negedge clk);
        check_broadcast(j);
        drive_lanes(active);
        #1;
        model_grants(j);
    endtask

    initial begin
        void'($urandom(72474));
        errors = 0;
        reset  = 1'b1;
        req    = 4'b0;
        held   = 4'b0;
        for (int c = 0; c < 4; c++) begin
            req_tag[c] = '0;
            req_op[c]  = isa_pkg::OP_ADD;
            req_a[c]   = '0;
            req_b[c]   = '0;
            for (int u = 0; u < `EXEC_NUM_MULT; u++) begin
                free_at[c][u] = 0;
            end
        end
        for (int s = 0; s < 16; s++) begin
            exp_valid[s] = 1'b0;
        end

        // lanes may ask while reset is high, none of them may be granted
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            req = 4'($urandom);
        end
        @(negedge clk);
        req   = 4'b0;
        reset = 1'b0;

        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            run_cycle(cycle, 1'b1);
        end
        // let waiting lanes finish, then drain the pipes
        while (held != 4'b0) begin
            run_cycle(cycle, 1'b0);
            cycle++;
        end
        repeat (MAX_LAT + 2) begin
            run_cycle(cycle, 1'b0);
            cycle++;
        end

        $display("value errors: %0d, assertion failures: %0d", errors,
                 u_exec_core.u_exec_core_assert.fail_count);
        if (errors == 0 && u_exec_core.u_exec_core_assert.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG * PERIOD);
        $display("watchdog expired before the test reached its end");
        $display("Checks failed");
        $finish;
    end

endmodule

/* bench/exec_core_assert.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module exec_core_assert (
    input logic               clk,
    input logic               reset,
    input logic [3:0]         req,
    input logic [3:0]         grant,
    input logic               cdb_valid,
    input isa_pkg::fu_class_e cdb_class
);

    // grant-to-broadcast latency per lane, in class order
    localparam int LAT [4] = '{`EXEC_LS_LAT, `EXEC_MULT_LAT, `EXEC_BR_LAT, `EXEC_ALU_LAT};

    int fail_count = 0;

    for (genvar c = 0; c < 4; c++) begin : g_lane
        // every grant comes back on the cdb lat+1 cycles later
        a_return: assert property (@(posedge clk) disable iff (reset)
            $past(grant[c], LAT[c] + 1) |-> cdb_valid && cdb_class == isa_pkg::fu_class_e'(c))
        else begin
            $error("grant on lane %0d was not broadcast after its latency", c);
            fail_count++;
        end

        // and no broadcast of this class without such a grant
        a_source: assert property (@(posedge clk) disable iff (reset)
            cdb_valid && cdb_class == isa_pkg::fu_class_e'(c) |-> $past(grant[c], LAT[c] + 1))
        else begin
            $error("broadcast of class %0d with no matching grant", c);
            fail_count++;
        end
    end

    a_reset_grant: assert property (@(posedge clk) reset || $past(reset) |-> grant == 4'b0)
    else begin
        $error("grant raised during or right after reset");
        fail_count++;
    end

    a_reset_cdb: assert property (@(posedge clk) $past(reset) |-> !cdb_valid)
    else begin
        $error("cdb_valid raised during or right after reset");
        fail_count++;
    end

    a_grant_req: assert property (@(posedge clk) (grant & ~req) == 4'b0)
    else begin
        $error("grant on a lane without a request");
        fail_count++;
    end

endmodule

bind exec_core exec_core_assert u_exec_core_assert (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .grant     (grant),
    .cdb_valid (cdb_valid),
    .cdb_class (cdb_class)
);

/* src/exec_core.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module exec_core (
    input  logic                      clk,
    input  logic                      reset,
    // request lanes, indexed by class
    input  logic [3:0]                req,
    input  sched_pkg::rob_tag_t [3:0] req_tag,
    input  isa_pkg::op_e [3:0]        req_op,
    input  isa_pkg::data_t [3:0]      req_a,
    input  isa_pkg::data_t [3:0]      req_b,
    output logic [3:0]                grant,
    // cdb broadcast
    output logic                      cdb_valid,
    output isa_pkg::fu_class_e        cdb_class,
    output sched_pkg::rob_tag_t       cdb_tag,
    output isa_pkg::data_t            cdb_data,
    output logic                      cdb_is_store
);

    sched_pkg::unit_idx_t [3:0]                  issue_unit_idx;
    logic                                        slot_valid;
    isa_pkg::fu_class_e                          slot_class;
    sched_pkg::unit_idx_t                        slot_unit;
    sched_pkg::rob_tag_t                         slot_tag;
    isa_pkg::data_t [`EXEC_NUM_UNITS-1:0]        unit_data;
    logic                                        ls_is_store;

    issue_unit u_issue_unit (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .req_tag        (req_tag),
        .grant          (grant),
        .issue_unit_idx (issue_unit_idx),
        .slot_valid     (slot_valid),
        .slot_class     (slot_class),
        .slot_unit      (slot_unit),
        .slot_tag       (slot_tag)
    );

    fu_bank u_fu_bank (
        .clk            (clk),
        .reset          (reset),
        .grant          (grant),
        .issue_unit_idx (issue_unit_idx),
        .req_op         (req_op),
        .req_a          (req_a),
        .req_b          (req_b),
        .unit_data      (unit_data),
        .ls_is_store    (ls_is_store)
    );

    cdb_driver u_cdb_driver (
        .clk          (clk),
        .reset        (reset),
        .slot_valid   (slot_valid),
        .slot_class   (slot_class),
        .slot_unit    (slot_unit),
        .slot_tag     (slot_tag),
        .unit_data    (unit_data),
        .ls_is_store  (ls_is_store),
        .cdb_valid    (cdb_valid),
        .cdb_class    (cdb_class),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .cdb_is_store (cdb_is_store)
    );

endmodule

/* src/cdb_driver.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module cdb_driver (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  slot_valid,
    input  isa_pkg::fu_class_e                    slot_class,
    input  sched_pkg::unit_idx_t                  slot_unit,
    input  sched_pkg::rob_tag_t                   slot_tag,
    input  isa_pkg::data_t [`EXEC_NUM_UNITS-1:0]  unit_data,
    input  logic                                  ls_is_store,
    output logic                                  cdb_valid,
    output isa_pkg::fu_class_e                    cdb_class,
    output sched_pkg::rob_tag_t                   cdb_tag,
    output isa_pkg::data_t                        cdb_data,
    output logic                                  cdb_is_store
);

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= slot_valid;
        end
    end

    // broadcast payload, qualified by cdb_valid
    always_ff @(posedge clk) begin
        cdb_class    <= slot_class;
        cdb_tag      <= slot_tag;
        cdb_data     <= unit_data[slot_unit];
        // store flag only from the ls unit
        cdb_is_store <= ls_is_store && (slot_class == isa_pkg::FU_LS);
    end

endmodule

/* src/fu_bank.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module fu_bank (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [3:0]                            grant,
    input  sched_pkg::unit_idx_t [3:0]            issue_unit_idx,
    input  isa_pkg::op_e [3:0]                    req_op,
    input  isa_pkg::data_t [3:0]                  req_a,
    input  isa_pkg::data_t [3:0]                  req_b,
    output isa_pkg::data_t [`EXEC_NUM_UNITS-1:0]  unit_data,
    output logic                                  ls_is_store
);

    localparam int NU    = `EXEC_NUM_UNITS;
    localparam int BR_U  = `EXEC_NUM_MULT + 1;
    localparam int ALU_U = `EXEC_NUM_MULT + 2;

    isa_pkg::fu_class_e [NU-1:0] unit_cls;
    logic [NU-1:0]               unit_grant;
    logic [NU-1:0]               issued_q;
    isa_pkg::op_e [NU-1:0]       op_q;
    isa_pkg::data_t [NU-1:0]     a_q;
    isa_pkg::data_t [NU-1:0]     b_q;

    sched_pkg::ls_payload_t ls_result;
    sched_pkg::ls_payload_t ls_out;
    isa_pkg::data_t         br_result;
    isa_pkg::data_t         alu_result;

    // which unit each lane's grant lands on
    always_comb begin
        for (int u = 0; u < NU; u++) begin
            unit_cls[u]   = sched_pkg::unit_class(sched_pkg::unit_idx_t'(u));
            unit_grant[u] = grant[unit_cls[u]]
                            && issue_unit_idx[unit_cls[u]] == sched_pkg::unit_idx_t'(u);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issued_q <= '0;
        end else begin
            issued_q <= unit_grant;
        end
    end

    // operands captured at the edge that ends the grant cycle
    always_ff @(posedge clk) begin
        for (int u = 0; u < NU; u++) begin
            if (unit_grant[u]) begin
                op_q[u] <= req_op[unit_cls[u]];
                a_q[u]  <= req_a[unit_cls[u]];
                b_q[u]  <= req_b[unit_cls[u]];
            end
        end
    end

    // effective address only, no data memory here
    assign ls_result.addr     = a_q[0] + b_q[0];
    assign ls_result.is_store = op_q[0][0];

    always_comb begin
        case (op_q[BR_U])
            isa_pkg::BR_EQ:  br_result = isa_pkg::data_t'(a_q[BR_U] == b_q[BR_U]);
            isa_pkg::BR_LTU: br_result = isa_pkg::data_t'(a_q[BR_U] < b_q[BR_U]);
            isa_pkg::BR_NE:  br_result = isa_pkg::data_t'(a_q[BR_U] != b_q[BR_U]);
            default:         br_result = isa_pkg::data_t'(1);
        endcase
    end

    always_comb begin
        case (op_q[ALU_U])
            isa_pkg::OP_ADD: alu_result = a_q[ALU_U] + b_q[ALU_U];
            isa_pkg::OP_SUB: alu_result = a_q[ALU_U] - b_q[ALU_U];
            isa_pkg::OP_AND: alu_result = a_q[ALU_U] & b_q[ALU_U];
            default:         alu_result = a_q[ALU_U] ^ b_q[ALU_U];
        endcase
    end

    latency_pipe #(.T(sched_pkg::ls_payload_t), .DEPTH(`EXEC_LS_LAT - 1)) u_ls_pipe (
        .clk(clk), .reset(reset), .load(issued_q[0]), .din(ls_result), .dout(ls_out)
    );

    assign unit_data[0] = ls_out.addr;
    assign ls_is_store  = ls_out.is_store;

    // one multiplier per unit, low half of the product
    for (genvar m = 1; m <= `EXEC_NUM_MULT; m++) begin : g_mult
        isa_pkg::data_t product;

        assign product = a_q[m] * b_q[m];

        latency_pipe #(.T(isa_pkg::data_t), .DEPTH(`EXEC_MULT_LAT - 1)) u_pipe (
            .clk(clk), .reset(reset), .load(issued_q[m]), .din(product), .dout(unit_data[m])
        );
    end

    latency_pipe #(.T(isa_pkg::data_t), .DEPTH(`EXEC_BR_LAT - 1)) u_br_pipe (
        .clk(clk), .reset(reset), .load(issued_q[BR_U]), .din(br_result),
        .dout(unit_data[BR_U])
    );

    latency_pipe #(.T(isa_pkg::data_t), .DEPTH(`EXEC_ALU_LAT - 1)) u_alu_pipe (
        .clk(clk), .reset(reset), .load(issued_q[ALU_U]), .din(alu_result),
        .dout(unit_data[ALU_U])
    );

endmodule

/* src/issue_unit.sv */
`timescale 1ns/100ps

`include "exec_cfg.svh"

module issue_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [3:0]                          req,
    input  sched_pkg::rob_tag_t [3:0]           req_tag,
    output logic [3:0]                          grant,
    output sched_pkg::unit_idx_t [3:0]          issue_unit_idx,
    output logic                                slot_valid,
    output isa_pkg::fu_class_e                  slot_class,
    output sched_pkg::unit_idx_t                slot_unit,
    output sched_pkg::rob_tag_t                 slot_tag
);

    localparam int NU = `EXEC_NUM_UNITS;

    // cycles left until each unit owns the cdb slot
    sched_pkg::count_t [NU-1:0]   count_q;
    sched_pkg::count_t [NU-1:0]   count_d;
    sched_pkg::rob_tag_t [NU-1:0] tag_q;
    sched_pkg::rob_tag_t [NU-1:0] tag_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        tag_q <= tag_d;
    end

    // the unit at count 1 owns this cycle's slot
    // at most one can be there, the grant logic sees to that
    always_comb begin
        slot_valid = 1'b0;
        slot_unit  = '0;
        for (int u = 0; u < NU; u++) begin
            if (count_q[u] == 4'd1) begin
                slot_valid = 1'b1;
                slot_unit  = sched_pkg::unit_idx_t'(u);
            end
        end
    end

    assign slot_class = sched_pkg::unit_class(slot_unit);
    assign slot_tag   = tag_q[slot_unit];

    // grant in priority order
    always_comb begin
        logic [15:0]       landing;
        logic              slot_taken;
        logic              found;
        sched_pkg::count_t lat;

        landing        = '0;
        grant          = '0;
        issue_unit_idx = '0;
        tag_d          = tag_q;
        for (int u = 0; u < NU; u++) begin
            count_d[u] = (count_q[u] != 4'd0) ? count_q[u] - 4'd1 : 4'd0;
        end

        for (int c = 0; c < 4; c++) begin
            lat = sched_pkg::class_lat(isa_pkg::fu_class_e'(c));

            // slot at t+lat already claimed by a running unit
            // or by a higher class granted this cycle
            slot_taken = landing[lat];
            for (int u = 0; u < NU; u++) begin
                if (count_q[u] == lat + 4'd1) begin
                    slot_taken = 1'b1;
                end
            end

            // lowest unit of this class that frees up in time
            found = 1'b0;
            for (int u = 0; u < NU; u++) begin
                if (!found
                    && sched_pkg::unit_class(sched_pkg::unit_idx_t'(u))
                       == isa_pkg::fu_class_e'(c)
                    && count_q[u] <= 4'd1) begin
                    found             = 1'b1;
                    issue_unit_idx[c] = sched_pkg::unit_idx_t'(u);
                end
            end

            // nothing is granted while reset is high
            if (!reset && req[c] && found && !slot_taken) begin
                grant[c]                   = 1'b1;
                landing[lat]               = 1'b1;
                count_d[issue_unit_idx[c]] = lat;
                tag_d[issue_unit_idx[c]]   = req_tag[c];
            end
        end
    end

endmodule

/* src/latency_pipe.sv */
`timescale 1ns/100ps

module latency_pipe #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  T     din,
    output T     dout
);

    generate
        if (DEPTH == 0) begin : g_direct
            // latency 1 unit, result goes straight to the slot
            assign dout = load ? din : '0;
        end else begin : g_chain
            T stage_q [DEPTH];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    // empty cycles shift zeros through
                    stage_q[0] <= load ? din : '0;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign dout = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

/* src/sched_pkg.sv */
`include "exec_cfg.svh"

package sched_pkg;

    typedef logic [`EXEC_TAG_LEN-1:0] rob_tag_t;
    typedef logic [3:0] count_t;
    typedef logic [$clog2(`EXEC_NUM_UNITS)-1:0] unit_idx_t;

    // what the ls pipe carries, low op bit marks a store
    typedef struct packed {
        isa_pkg::data_t addr;
        logic           is_store;
    } ls_payload_t;

    // unit 0 is ls, then the multipliers, then branch, alu last
    function automatic isa_pkg::fu_class_e unit_class(unit_idx_t u);
        if (u == 0) return isa_pkg::FU_LS;
        if (u <= `EXEC_NUM_MULT) return isa_pkg::FU_MULT;
        if (u == `EXEC_NUM_MULT + 1) return isa_pkg::FU_BR;
        return isa_pkg::FU_ALU;
    endfunction

    function automatic count_t class_lat(isa_pkg::fu_class_e c);
        case (c)
            isa_pkg::FU_LS:   return count_t'(`EXEC_LS_LAT);
            isa_pkg::FU_MULT: return count_t'(`EXEC_MULT_LAT);
            isa_pkg::FU_BR:   return count_t'(`EXEC_BR_LAT);
            default:          return count_t'(`EXEC_ALU_LAT);
        endcase
    endfunction

endpackage

/* src/isa_pkg.sv */
`include "exec_cfg.svh"

package isa_pkg;

    // functional-unit classes, highest issue priority first
    typedef enum logic [1:0] {
        FU_LS   = 2'd0,
        FU_MULT = 2'd1,
        FU_BR   = 2'd2,
        FU_ALU  = 2'd3
    } fu_class_e;

    typedef logic [`EXEC_XLEN-1:0] data_t;

    // per-class opcode, named after the alu meaning
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } op_e;

    // branch compares share the same codes
    localparam op_e BR_EQ     = OP_ADD;
    localparam op_e BR_LTU    = OP_SUB;
    localparam op_e BR_NE     = OP_AND;
    localparam op_e BR_ALWAYS = OP_XOR;

endpackage

/* include/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath and tag widths
`define EXEC_XLEN 32
`define EXEC_TAG_LEN 5

// unit counts
// units are ordered ls, multipliers, branch, alu
`define EXEC_NUM_MULT 2
`define EXEC_NUM_UNITS (1 + `EXEC_NUM_MULT + 1 + 1)

// issue-to-slot latencies, each 1..14 for the 4-bit countdowns
`define EXEC_LS_LAT 3
`define EXEC_MULT_LAT 4
`define EXEC_BR_LAT 1
`define EXEC_ALU_LAT 2

`endif
